/* sim.f */
+incdir+design
design/ahb_mon_pkg.sv
design/ahb_master_rules.sv
design/ahb_slave_rules.sv
design/ahb_violation_log.sv
design/ahb_protocol_monitor.sv
tb/tb_ahb_protocol_monitor.sv

/* Bender.yml */
package:
  name: ahb_protocol_monitor

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/ahb_mon_pkg.sv
      - design/ahb_master_rules.sv
      - design/ahb_slave_rules.sv
      - design/ahb_violation_log.sv
      - design/ahb_protocol_monitor.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/tb_ahb_protocol_monitor.sv

/* tb/tb_ahb_protocol_monitor.sv */
// Drives HWRITE low throughout so write data stability is not exercised, and sizes stay up to WORD
`timescale 1ns/10ps
`include "ahb_mon_defines.svh"

module tb_ahb_protocol_monitor;

  localparam int N_BURSTS     = 60;
  // Longest burst is 16 beats with up to two waits and one BUSY each
  localparam int CYC_PER_BURST = 16 * 4 + 6;
  localparam int SCHED_CYCLES  = 16 + N_BURSTS * CYC_PER_BURST + 300;

  // One-hot markers in flag order
  localparam ahb_mon_pkg::viol_t M_TRANS = 7'b1000000;
  localparam ahb_mon_pkg::viol_t M_WAIT  = 7'b0100000;
  localparam ahb_mon_pkg::viol_t M_BURST = 7'b0010000;
  localparam ahb_mon_pkg::viol_t M_ADDR  = 7'b0001000;
  localparam ahb_mon_pkg::viol_t M_SIZE  = 7'b0000100;
  localparam ahb_mon_pkg::viol_t M_IDLE  = 7'b0000010;
  localparam ahb_mon_pkg::viol_t M_ERR   = 7'b0000001;

  logic                    HCLK;
  logic                    HRESETn;
  logic [`AHB_ADDR_W-1:0]  HADDR;
  logic [`AHB_DATA_W-1:0]  HWDATA;
  logic                    HWRITE;
  logic [2:0]              HSIZE;
  logic [2:0]              HBURST;
  logic [1:0]              HTRANS;
  logic                    HREADY;
  logic                    HRESP;
  logic                    clr;
  logic                    viol_strobe;
  ahb_mon_pkg::viol_t      viol_flags;
  logic [`VIOL_CNT_W-1:0]  viol_count;
  ahb_mon_pkg::viol_code_t first_viol;

  integer                  seed = 32'he33859a0;
  int                      errors = 0;
  int                      n_faults = 0;
  logic                    last_xfer;
  ahb_mon_pkg::viol_t      exp_mark;
  ahb_mon_pkg::viol_t      mark_d1;
  ahb_mon_pkg::viol_t      exp_flags;
  logic [`VIOL_CNT_W-1:0]  exp_cnt;
  ahb_mon_pkg::viol_code_t exp_first;

  ahb_protocol_monitor uut (
    .HCLK(HCLK), .HRESETn(HRESETn), .HADDR(HADDR), .HWDATA(HWDATA), .HWRITE(HWRITE),
    .HSIZE(HSIZE), .HBURST(HBURST), .HTRANS(HTRANS), .HREADY(HREADY), .HRESP(HRESP),
    .clr(clr), .viol_strobe(viol_strobe), .viol_flags(viol_flags),
    .viol_count(viol_count), .first_viol(first_viol)
  );

  always #2 HCLK = ~HCLK;

  ////////////////////////////////////////
  // Reference model of the log
  ////////////////////////////////////////

  // Codes run 1 to 7 in flag order, lowest code wins
  function automatic ahb_mon_pkg::viol_code_t lowest_code(input ahb_mon_pkg::viol_t m);
    logic [2:0] code;
    code = 3'd0;
    for (int i = 0; i < 7; i++)
    begin
      if (m[i])
        code = 3'(7 - i);
    end
    return ahb_mon_pkg::viol_code_t'(code);
  endfunction

  // mark_d1 holds the marker sampled one edge earlier
  always @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      mark_d1   <= '0;
      exp_flags <= '0;
      exp_cnt   <= '0;
      exp_first <= ahb_mon_pkg::NONE;
    end
    else
    begin
      mark_d1 <= exp_mark;
      if (clr)
      begin
        exp_flags <= mark_d1;
        exp_cnt   <= (|mark_d1) ? 1 : 0;
        exp_first <= lowest_code(mark_d1);
      end
      else
      begin
        exp_flags <= exp_flags | mark_d1;
        exp_cnt   <= exp_cnt + (|mark_d1);
        if (exp_first == ahb_mon_pkg::NONE)
          exp_first <= lowest_code(mark_d1);
      end
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Fault sample gives a strobe and its flag two edges later
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    (|exp_mark) |-> ##2 (viol_strobe && ((viol_flags & $past(exp_mark, 2)) != 0)))
  else
  begin
    errors++;
    $display("No strobe with the marked flag two edges after an injected fault");
  end

  // Clean sample gives no strobe
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(|exp_mark) |-> ##2 !viol_strobe)
  else
  begin
    errors++;
    $display("ERROR viol_strobe exp 0 got %h", $sampled(viol_strobe));
  end

  assert property (@(posedge HCLK) disable iff (!HRESETn) viol_count == exp_cnt)
  else
  begin
    errors++;
    $display("ERROR viol_count exp %h got %h", $sampled(exp_cnt), $sampled(viol_count));
  end

  assert property (@(posedge HCLK) disable iff (!HRESETn) viol_flags == exp_flags)
  else
  begin
    errors++;
    $display("ERROR viol_flags exp %h got %h", $sampled(exp_flags), $sampled(viol_flags));
  end

  assert property (@(posedge HCLK) disable iff (!HRESETn) first_viol == exp_first)
  else
  begin
    errors++;
    $display("ERROR first_viol exp %h got %h", $sampled(exp_first), $sampled(first_viol));
  end

  // Outputs are cleared coming out of reset
  assert property (@(posedge HCLK) $rose(HRESETn) |->
    (!viol_strobe && viol_flags == '0 && viol_count == '0 && first_viol == ahb_mon_pkg::NONE))
  else
  begin
    errors++;
    $display("ERROR reset status exp 0 got viol_strobe %h viol_flags %h",
             $sampled(viol_strobe), $sampled(viol_flags));
    $display("ERROR reset status exp 0 got viol_count %h first_viol %h",
             $sampled(viol_count), $sampled(first_viol));
  end

  ////////////////////////////////////////
  // Bus driver
  ////////////////////////////////////////

  // One cycle of pins plus the marker for that sample
  task automatic drive(input logic [1:0] t, input logic [31:0] a, input logic [2:0] b,
                       input logic [2:0] s, input logic rdy, input logic rsp,
                       input ahb_mon_pkg::viol_t m);
    @(negedge HCLK);
    HTRANS   = t;
    HADDR    = a;
    HBURST   = b;
    HSIZE    = s;
    HREADY   = rdy;
    HRESP    = rsp;
    exp_mark = m;
    if (m != '0)
      n_faults++;
  endtask

  task automatic idle(input int n);
    repeat (n) drive(ahb_mon_pkg::IDLE, 32'h0, 3'd0, 3'd2, 1'b1, 1'b0, '0);
    last_xfer = 1'b0;
  endtask

  // Waits only land on the data phase of a real transfer
  task automatic beat(input logic [1:0] t, input logic [31:0] a, input logic [2:0] b,
                      input logic [2:0] s);
    int unsigned w;
    w = last_xfer ? ($unsigned($random(seed)) % 3) : 0;
    repeat (w) drive(t, a, b, s, 1'b0, 1'b0, '0);
    drive(t, a, b, s, 1'b1, 1'b0, '0);
    last_xfer = (t == ahb_mon_pkg::NONSEQ) || (t == ahb_mon_pkg::SEQ);
  endtask

  // Next beat address, wrapping inside a span of beats times size
  function automatic logic [31:0] next_addr(input logic [31:0] a, input logic [2:0] b,
                                            input logic [2:0] s);
    logic [31:0] inc;
    logic [31:0] span;
    inc = 32'd1 << s;
    case (b)
      3'd2:    span = inc * 4;
      3'd4:    span = inc * 8;
      3'd6:    span = inc * 16;
      default: span = 32'd0;
    endcase
    if (span == 0)
      return a + inc;
    return (a & ~(span - 1)) | ((a + inc) & (span - 1));
  endfunction

  task automatic run_burst();
    logic [2:0]  b;
    logic [2:0]  s;
    logic [31:0] a;
    int          beats;
    b = 3'($random(seed));
    s = 3'($unsigned($random(seed)) % 3);
    a = $random(seed) & 32'h0000_fff0;
    case (b)
      3'd0:       beats = 1;
      3'd1:       beats = 1 + $unsigned($random(seed)) % 4;
      3'd2, 3'd3: beats = 4;
      3'd4, 3'd5: beats = 8;
      default:    beats = 16;
    endcase
    beat(ahb_mon_pkg::NONSEQ, a, b, s);
    for (int i = 1; i < beats; i++)
    begin
      a = next_addr(a, b, s);
      // BUSY only between beats
      if ($unsigned($random(seed)) % 4 == 0)
        beat(ahb_mon_pkg::BUSY, a, b, s);
      beat(ahb_mon_pkg::SEQ, a, b, s);
    end
    // Legal two-cycle ERROR after a single
    if ((b == 3'd0) && ($unsigned($random(seed)) % 3 == 0))
    begin
      drive(ahb_mon_pkg::IDLE, 32'h0, 3'd0, s, 1'b0, 1'b1, '0);
      drive(ahb_mon_pkg::IDLE, 32'h0, 3'd0, s, 1'b1, 1'b1, '0);
      last_xfer = 1'b0;
    end
    if ($unsigned($random(seed)) % 2 == 0)
      beat(ahb_mon_pkg::IDLE, 32'h0, 3'd0, s);
  endtask

  task automatic pulse_clr();
    @(negedge HCLK);
    clr = 1'b1;
    @(negedge HCLK);
    clr = 1'b0;
  endtask

  ////////////////////////////////////////
  // Injected faults
  ////////////////////////////////////////

  task automatic fault_seq_outside();
    idle(3);
    drive(ahb_mon_pkg::SEQ, 32'h100, 3'd1, 3'd2, 1'b1, 1'b0, M_TRANS);
  endtask

  task automatic fault_early_nonseq();
    idle(3);
    drive(ahb_mon_pkg::NONSEQ, 32'h200, 3'd3, 3'd2, 1'b1, 1'b0, '0);
    drive(ahb_mon_pkg::SEQ, 32'h204, 3'd3, 3'd2, 1'b1, 1'b0, '0);
    drive(ahb_mon_pkg::NONSEQ, 32'h300, 3'd0, 3'd2, 1'b1, 1'b0, M_TRANS);
  endtask

  task automatic fault_wait_addr();
    idle(3);
    drive(ahb_mon_pkg::NONSEQ, 32'h400, 3'd0, 3'd2, 1'b1, 1'b0, '0);
    drive(ahb_mon_pkg::NONSEQ, 32'h410, 3'd0, 3'd2, 1'b0, 1'b0, '0);
    drive(ahb_mon_pkg::NONSEQ, 32'h420, 3'd0, 3'd2, 1'b1, 1'b0, M_WAIT);
  endtask

  task automatic fault_size_change();
    idle(3);
    drive(ahb_mon_pkg::NONSEQ, 32'h500, 3'd1, 3'd2, 1'b1, 1'b0, '0);
    drive(ahb_mon_pkg::SEQ, 32'h504, 3'd1, 3'd2, 1'b1, 1'b0, '0);
    drive(ahb_mon_pkg::SEQ, 32'h508, 3'd1, 3'd1, 1'b1, 1'b0, M_BURST);
  endtask

  // WRAP8 of words should wrap 0x61C to 0x600
  task automatic fault_wrap_addr();
    logic [31:0] a;
    idle(3);
    drive(ahb_mon_pkg::NONSEQ, 32'h618, 3'd4, 3'd2, 1'b1, 1'b0, '0);
    drive(ahb_mon_pkg::SEQ, 32'h61C, 3'd4, 3'd2, 1'b1, 1'b0, '0);
    drive(ahb_mon_pkg::SEQ, 32'h620, 3'd4, 3'd2, 1'b1, 1'b0, M_ADDR);
    a = 32'h620;
    // Finish the burst from the address actually sent
    repeat (5)
    begin
      a = next_addr(a, 3'd4, 3'd2);
      drive(ahb_mon_pkg::SEQ, a, 3'd4, 3'd2, 1'b1, 1'b0, '0);
    end
  endtask

  task automatic fault_dword();
    idle(3);
    drive(ahb_mon_pkg::NONSEQ, 32'h700, 3'd0, 3'd3, 1'b1, 1'b0, M_SIZE);
  endtask

  task automatic fault_idle_wait();
    idle(3);
    drive(ahb_mon_pkg::IDLE, 32'h0, 3'd0, 3'd2, 1'b0, 1'b0, M_IDLE);
  endtask

  task automatic fault_short_error();
    idle(3);
    drive(ahb_mon_pkg::NONSEQ, 32'h800, 3'd0, 3'd2, 1'b1, 1'b0, '0);
    drive(ahb_mon_pkg::IDLE, 32'h0, 3'd0, 3'd2, 1'b1, 1'b1, M_ERR);
  endtask

  ////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////

  initial
  begin
    HCLK      = 1'b0;
    HRESETn   = 1'b0;
    HADDR     = '0;
    HWDATA    = 32'h5a5a_c3c3;
    HWRITE    = 1'b0;
    HSIZE     = 3'd2;
    HBURST    = 3'd0;
    HTRANS    = 2'b00;
    HREADY    = 1'b1;
    HRESP     = 1'b0;
    clr       = 1'b0;
    exp_mark  = '0;
    last_xfer = 1'b0;
    repeat (16) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    idle(4);
    // Legal traffic first
    repeat (N_BURSTS) run_burst();
    idle(4);
    fault_seq_outside();
    fault_early_nonseq();
    fault_wait_addr();
    fault_size_change();
    fault_wrap_addr();
    fault_dword();
    fault_idle_wait();
    fault_short_error();
    idle(4);
    // First code after a clear must stick
    pulse_clr();
    idle(2);
    fault_wait_addr();
    fault_seq_outside();
    fault_short_error();
    idle(4);
    pulse_clr();
    idle(4);
    $display("Checks failed: %0d, faults injected: %0d", errors, n_faults);
    if (errors == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  initial
  begin
    #(SCHED_CYCLES * 4 + 400);
    $display("Timeout: the run did not finish within the scheduled cycles");
    $display("Test failures found");
    $finish;
  end

endmodule

/* design/ahb_protocol_monitor.sv */
// Passive monitor with two edges from offending sample to viol_strobe and no HSEL or HRDATA checks
`timescale 1ns/10ps
`include "ahb_mon_defines.svh"

module ahb_protocol_monitor (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic [`AHB_ADDR_W-1:0]  HADDR,
  input  logic [`AHB_DATA_W-1:0]  HWDATA,
  input  logic                    HWRITE,
  input  logic [2:0]              HSIZE,
  input  logic [2:0]              HBURST,
  input  logic [1:0]              HTRANS,
  input  logic                    HREADY,
  input  logic                    HRESP,
  input  logic                    clr,
  output logic                    viol_strobe,
  output ahb_mon_pkg::viol_t      viol_flags,
  output logic [`VIOL_CNT_W-1:0]  viol_count,
  output ahb_mon_pkg::viol_code_t first_viol
);

  ahb_mon_pkg::ahb_bus_t bus;
  ahb_mon_pkg::viol_t    mst_viol;
  ahb_mon_pkg::viol_t    slv_viol;

  // Raw pins into one sample
  assign bus = '{haddr: HADDR, hwdata: HWDATA, hwrite: HWRITE,
                 hsize: ahb_mon_pkg::hsize_t'(HSIZE), hburst: ahb_mon_pkg::hburst_t'(HBURST),
                 htrans: ahb_mon_pkg::htrans_t'(HTRANS), hready: HREADY,
                 hresp: ahb_mon_pkg::hresp_t'(HRESP)};

  ahb_master_rules u_master (.HCLK(HCLK), .HRESETn(HRESETn), .bus(bus), .viol(mst_viol));

  ahb_slave_rules u_slave (.HCLK(HCLK), .HRESETn(HRESETn), .bus(bus), .viol(slv_viol));

  // Merge both flag sets into the status outputs
  ahb_violation_log u_log (
    .HCLK(HCLK), .HRESETn(HRESETn), .clr(clr),
    .mst_viol(mst_viol), .slv_viol(slv_viol),
    .viol_strobe(viol_strobe), .viol_flags(viol_flags),
    .viol_count(viol_count), .first_viol(first_viol)
  );

endmodule

/* design/ahb_violation_log.sv */
// Status clears only through clr and a violation in the clear cycle starts the new record
`timescale 1ns/10ps
`include "ahb_mon_defines.svh"

module ahb_violation_log (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  input  logic                    clr,
  input  ahb_mon_pkg::viol_t      mst_viol,
  input  ahb_mon_pkg::viol_t      slv_viol,
  output logic                    viol_strobe,
  output ahb_mon_pkg::viol_t      viol_flags,
  output logic [`VIOL_CNT_W-1:0]  viol_count,
  output ahb_mon_pkg::viol_code_t first_viol
);

  ahb_mon_pkg::viol_t      merged;
  logic                    any_viol;
  logic                    cnt_max;
  ahb_mon_pkg::viol_code_t new_code;

  assign merged   = mst_viol | slv_viol;
  assign any_viol = |merged;
  assign cnt_max  = &viol_count;

  // Lowest-numbered rule wins
  always_comb
  begin
    if (merged.trans_seq)
      new_code = ahb_mon_pkg::TRANS_SEQ;
    else if (merged.wait_stable)
      new_code = ahb_mon_pkg::WAIT_STABLE;
    else if (merged.burst_stable)
      new_code = ahb_mon_pkg::BURST_STABLE;
    else if (merged.addr_seq)
      new_code = ahb_mon_pkg::ADDR_SEQ;
    else if (merged.size_range)
      new_code = ahb_mon_pkg::SIZE_RANGE;
    else if (merged.idle_resp)
      new_code = ahb_mon_pkg::IDLE_RESP;
    else if (merged.err_seq)
      new_code = ahb_mon_pkg::ERR_SEQ;
    else
      new_code = ahb_mon_pkg::NONE;
  end

  ////////////////////////////////////////
  // Sticky status
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      viol_strobe <= 1'b0;
      viol_flags  <= '0;
      viol_count  <= '0;
      first_viol  <= ahb_mon_pkg::NONE;
    end
    else
    begin
      // One pulse per cycle with any flag
      viol_strobe <= any_viol;
      if (clr)
      begin
        viol_flags <= merged;
        viol_count <= {{(`VIOL_CNT_W-1){1'b0}}, any_viol};
        first_viol <= new_code;
      end
      else
      begin
        viol_flags <= viol_flags | merged;
        if (any_viol && !cnt_max)
          viol_count <= viol_count + 1'b1;
        // First code locks until the next clear
        if (first_viol == ahb_mon_pkg::NONE)
          first_viol <= new_code;
      end
    end
  end

  // Count only moves down through a clear
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    !clr |=> (viol_count >= $past(viol_count)));

endmodule

/* design/ahb_slave_rules.sv */
// Zero-wait rules apply only to an IDLE or BUSY that saw HREADY high
`timescale 1ns/10ps

module ahb_slave_rules (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahb_mon_pkg::ahb_bus_t bus,
  output ahb_mon_pkg::viol_t    viol
);

  ahb_mon_pkg::htrans_t prev_htrans;
  logic                 prev_hready;
  ahb_mon_pkg::hresp_t  prev_hresp;
  logic                 no_wait_due;
  logic                 err_first;
  logic                 err_second;
  ahb_mon_pkg::viol_t   viol_nxt;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prev_htrans <= ahb_mon_pkg::IDLE;
      prev_hready <= 1'b1;
      prev_hresp  <= ahb_mon_pkg::OKAY;
    end
    else
    begin
      prev_htrans <= bus.htrans;
      prev_hready <= bus.hready;
      prev_hresp  <= bus.hresp;
    end
  end

  // Accepted IDLE or BUSY owes a zero-wait OKAY
  assign no_wait_due = prev_hready &&
    ((prev_htrans == ahb_mon_pkg::IDLE) || (prev_htrans == ahb_mon_pkg::BUSY));

  // ERROR shape is one stalled cycle then one ready cycle
  assign err_first  = !prev_hready && (prev_hresp == ahb_mon_pkg::ERROR);
  assign err_second = bus.hready && (bus.hresp == ahb_mon_pkg::ERROR);

  always_comb
  begin
    viol_nxt = '0;
    viol_nxt.idle_resp = no_wait_due && (!bus.hready || (bus.hresp != ahb_mon_pkg::OKAY));
    // Either half of the pair showing up alone
    viol_nxt.err_seq = (err_second && !err_first) || (err_first && !err_second);
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      viol <= '0;
    else
      viol <= viol_nxt;
  end

  // Slave must drive a defined response once out of reset
  assert property (@(posedge HCLK) disable iff (!HRESETn) !$isunknown(bus.hresp));

endmodule

/* design/ahb_master_rules.sv */
// Single master without HSEL decode and an ERROR response lets the master cancel a burst
`timescale 1ns/10ps
`include "ahb_mon_defines.svh"

module ahb_master_rules (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  ahb_mon_pkg::ahb_bus_t bus,
  output ahb_mon_pkg::viol_t    viol
);

  ahb_mon_pkg::ahb_bus_t  prev_bus;
  logic                   burst_act;
  logic [3:0]             beat_cnt;
  logic [`AHB_ADDR_W-1:0] beat_addr;
  ahb_mon_pkg::hsize_t    beat_size;
  logic                   dp_write;
  logic                   xfer;
  logic                   fixed_mid;
  logic [`AHB_ADDR_W-1:0] exp_addr;
  logic [10:0]            size_bits;
  ahb_mon_pkg::viol_t     viol_nxt;

  // Beats still to come after the NONSEQ of a burst
  function automatic logic [3:0] beats_left(input ahb_mon_pkg::hburst_t hb);
    case (hb)
      ahb_mon_pkg::WRAP4, ahb_mon_pkg::INCR4:   beats_left = 4'd3;
      ahb_mon_pkg::WRAP8, ahb_mon_pkg::INCR8:   beats_left = 4'd7;
      ahb_mon_pkg::WRAP16, ahb_mon_pkg::INCR16: beats_left = 4'd15;
      default:                                  beats_left = 4'd0;
    endcase
  endfunction

  // NONSEQ or SEQ in the address phase
  assign xfer = (bus.htrans == ahb_mon_pkg::NONSEQ) || (bus.htrans == ahb_mon_pkg::SEQ);

  // INCR keeps the count at zero
  assign fixed_mid = burst_act && (beat_cnt != 4'd0);

  ////////////////////////////////////////
  // Previous sample and burst tracking
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      prev_bus <= '{haddr: '0, hwdata: '0, hwrite: 1'b0, hsize: ahb_mon_pkg::BYTE,
                    hburst: ahb_mon_pkg::SINGLE, htrans: ahb_mon_pkg::IDLE,
                    hready: 1'b1, hresp: ahb_mon_pkg::OKAY};
    end
    else
    begin
      prev_bus <= bus;
    end
  end

  // Burst position moves only when the address phase is accepted
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      burst_act <= 1'b0;
      beat_cnt  <= 4'd0;
      dp_write  <= 1'b0;
    end
    else if (bus.hready)
    begin
      dp_write <= xfer && bus.hwrite;
      case (bus.htrans)
        ahb_mon_pkg::NONSEQ:
        begin
          burst_act <= (bus.hburst != ahb_mon_pkg::SINGLE);
          beat_cnt  <= beats_left(bus.hburst);
        end
        ahb_mon_pkg::SEQ:
        begin
          // Last fixed beat closes the burst
          if (beat_cnt == 4'd1)
            burst_act <= 1'b0;
          if (beat_cnt != 4'd0)
            beat_cnt <= beat_cnt - 4'd1;
        end
        ahb_mon_pkg::IDLE:
        begin
          burst_act <= 1'b0;
          beat_cnt  <= 4'd0;
        end
        default:
          burst_act <= burst_act;  // BUSY holds the position
      endcase
    end
  end

  // Address and size of the last accepted beat
  always_ff @(posedge HCLK)
  begin
    if (bus.hready && xfer)
    begin
      beat_addr <= bus.haddr;
      beat_size <= bus.hsize;
    end
  end

  ////////////////////////////////////////
  // Rule checks
  ////////////////////////////////////////

  // Next beat address with wrap at the WRAPn boundary
  always_comb
  begin
    logic [`AHB_ADDR_W-1:0] incr;
    logic [`AHB_ADDR_W-1:0] wrap_mask;

    incr = {{(`AHB_ADDR_W-8){1'b0}}, 8'd1} << beat_size;
    case (bus.hburst)
      ahb_mon_pkg::WRAP4:  wrap_mask = (incr << 2) - 1'b1;
      ahb_mon_pkg::WRAP8:  wrap_mask = (incr << 3) - 1'b1;
      ahb_mon_pkg::WRAP16: wrap_mask = (incr << 4) - 1'b1;
      default:             wrap_mask = '1;
    endcase
    exp_addr = (beat_addr & ~wrap_mask) | ((beat_addr + incr) & wrap_mask);
  end

  // Transfer width in bits
  assign size_bits = 11'd8 << bus.hsize;

  always_comb
  begin
    viol_nxt = '0;
    // SEQ and BUSY need a burst, IDLE and NONSEQ may not cut a fixed one short
    if ((bus.htrans == ahb_mon_pkg::SEQ) || (bus.htrans == ahb_mon_pkg::BUSY))
      viol_nxt.trans_seq = !burst_act;
    else
      viol_nxt.trans_seq = fixed_mid && (bus.hresp == ahb_mon_pkg::OKAY);
    // Stalled address phase and write data must hold
    viol_nxt.wait_stable = !prev_bus.hready && (prev_bus.hresp == ahb_mon_pkg::OKAY) &&
      ((((prev_bus.htrans == ahb_mon_pkg::NONSEQ) || (prev_bus.htrans == ahb_mon_pkg::SEQ)) &&
        ((bus.haddr != prev_bus.haddr) || (bus.htrans != prev_bus.htrans) ||
         (bus.hwrite != prev_bus.hwrite) || (bus.hsize != prev_bus.hsize) ||
         (bus.hburst != prev_bus.hburst))) ||
       (dp_write && (bus.hwdata != prev_bus.hwdata)));
    // Control held across beats
    viol_nxt.burst_stable = burst_act &&
      ((bus.htrans == ahb_mon_pkg::SEQ) || (bus.htrans == ahb_mon_pkg::BUSY)) &&
      ((bus.hsize != prev_bus.hsize) || (bus.hburst != prev_bus.hburst) ||
       (bus.hwrite != prev_bus.hwrite));
    viol_nxt.addr_seq   = burst_act && (bus.htrans == ahb_mon_pkg::SEQ) && (bus.haddr != exp_addr);
    viol_nxt.size_range = xfer && (size_bits > `AHB_DATA_W);
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      viol <= '0;
    else
      viol <= viol_nxt;
  end

  // Remaining beats only exist inside an open burst
  assert property (@(posedge HCLK) disable iff (!HRESETn)
    (beat_cnt != 4'd0) |-> burst_act);

endmodule

/* design/ahb_mon_pkg.sv */
// Types only and widths from ahb_mon_defines.svh with HSEL, HPROT, HMASTLOCK and HRDATA not carried
`include "ahb_mon_defines.svh"

package ahb_mon_pkg;

  // Transfer type
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    BUSY   = 2'b01,
    NONSEQ = 2'b10,
    SEQ    = 2'b11
  } htrans_t;

  // Burst type
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_t;

  // Transfer size as log2 of the byte count
  typedef enum logic [2:0] {BYTE, HWORD, WORD, DWORD, B128, B256, B512, B1024} hsize_t;

  // AHB3-Lite response carries OKAY and ERROR only
  typedef enum logic {OKAY = 1'b0, ERROR = 1'b1} hresp_t;

  // One bus sample, 75 bits
  typedef struct packed {
    logic [`AHB_ADDR_W-1:0] haddr;
    logic [`AHB_DATA_W-1:0] hwdata;
    logic                   hwrite;
    hsize_t                 hsize;
    hburst_t                hburst;
    htrans_t                htrans;
    logic                   hready;
    hresp_t                 hresp;
  } ahb_bus_t;

  // Rule flags, code order follows field order
  typedef struct packed {
    logic trans_seq;
    logic wait_stable;
    logic burst_stable;
    logic addr_seq;
    logic size_range;
    logic idle_resp;
    logic err_seq;
  } viol_t;

  // Rule codes for the first-violation record
  typedef enum logic [2:0] {
    NONE, TRANS_SEQ, WAIT_STABLE, BURST_STABLE, ADDR_SEQ, SIZE_RANGE, IDLE_RESP, ERR_SEQ
  } viol_code_t;

endpackage

/* design/ahb_mon_defines.svh */
// Widths are fixed at build time and AHB_DATA_W caps the widest legal HSIZE
`ifndef AHB_MON_DEFINES_SVH
`define AHB_MON_DEFINES_SVH

////////////////////////////////////////
// AHB bus widths
////////////////////////////////////////

// Address bus width in bits
`define AHB_ADDR_W 32

// Write data bus width in bits
// Any HSIZE wider than this is a size_range break
`define AHB_DATA_W 32

////////////////////////////////////////
// Violation log
////////////////////////////////////////

// Violation counter width
// The counter sticks at all ones
`define VIOL_CNT_W 16

`endif
